// File: pong.f
source/screen_pkg.sv
source/game_pkg.sv
source/court_painter.sv
source/paddle_unit.sv
source/ball_unit.sv
source/draw_sequencer.sv
source/pong_top.sv
verif/pong_chk.sv
verif/pong_tb.sv

// File: source/ball_unit.sv
// Ball motion, wall and paddle bounces, angle zones, scoring and re-serve, one step per frame
module ball_unit (
	input logic clk,
	input logic resetn,
	input logic frame_update,
	input screen_pkg::y_t paddle1_y,
	input screen_pkg::y_t paddle2_y,
	output screen_pkg::x_t ball_x,
	output screen_pkg::y_t ball_y,
	output game_pkg::score_t score_p1,
	output game_pkg::score_t score_p2
);
	import screen_pkg::*;
	import game_pkg::*;

	// Direction, high for rightward and downward
	logic dir_right;
	logic dir_down;

	// Frames per step and frame counters per axis
	period_t x_period;
	period_t y_period;
	period_t x_cnt;
	period_t y_cnt;

	// Scoring edges
	logic left_out;
	logic right_out;

	// Paddle contact decode
	logic at_p1_col;
	logic at_p2_col;
	y_t contact_top;
	y_t offset;
	logic on_paddle;
	logic [3:0] zone;
	logic [2:0] steep;

	// Values after bounces and contact
	logic next_right;
	logic next_down;
	period_t next_x_period;
	period_t next_y_period;
	period_t x_cnt_inc;
	period_t y_cnt_inc;

	assign left_out = (ball_x <= 8'd1);
	assign right_out = (ball_x >= x_t'(SCREEN_W - 1));

	// Ball column just inside each paddle
	assign at_p1_col = (ball_x == P1_X + 8'd2);
	assign at_p2_col = (ball_x == P2_X - 8'd2);
	assign contact_top = at_p1_col ? paddle1_y : paddle2_y;
	assign offset = ball_y - contact_top;
	assign on_paddle = (at_p1_col || at_p2_col) && (ball_y >= contact_top)
		&& (offset < y_t'(PADDLE_LEN));

	// Two rows per zone, steepest at both paddle ends
	assign zone = 4'(offset / y_t'(ZONE_ROWS));
	assign steep = (zone < 4'(ZONE_COUNT / 2)) ? 3'(zone) : 3'(ZONE_COUNT - 1 - zone);

	always_comb begin
		next_right = dir_right;
		next_down = dir_down;
		next_x_period = x_period;
		next_y_period = y_period;
		// Top and bottom walls
		if (ball_y <= BALL_Y_MIN) begin
			next_down = 1'b1;
		end else if (ball_y >= BALL_Y_MAX) begin
			next_down = 1'b0;
		end
		// Paddle hit wins over a wall bounce
		if (on_paddle) begin
			next_right = at_p1_col;
			next_down = (zone >= 4'(ZONE_COUNT / 2));
			next_x_period = zone_x_period[steep];
			next_y_period = zone_y_period[steep];
		end
		x_cnt_inc = x_cnt + 1'b1;
		y_cnt_inc = y_cnt + 1'b1;
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			ball_x <= BALL_START_X;
			ball_y <= BALL_START_Y;
			dir_right <= 1'b1;
			dir_down <= 1'b1;
			x_period <= zone_x_period[STEEP_45];
			y_period <= zone_y_period[STEEP_45];
			x_cnt <= '0;
			y_cnt <= '0;
			score_p1 <= '0;
			score_p2 <= '0;
		end else if (frame_update) begin
			if (left_out || right_out) begin
				// Point scored, re-serve toward the side that lost
				if (left_out) begin
					score_p2 <= score_p2 + 1'b1;
				end else begin
					score_p1 <= score_p1 + 1'b1;
				end
				ball_x <= BALL_START_X;
				ball_y <= BALL_START_Y;
				dir_right <= !left_out;
				dir_down <= 1'b1;
				x_period <= zone_x_period[STEEP_45];
				y_period <= zone_y_period[STEEP_45];
				x_cnt <= '0;
				y_cnt <= '0;
			end else begin
				dir_right <= next_right;
				dir_down <= next_down;
				x_period <= next_x_period;
				y_period <= next_y_period;
				// Step an axis once its counter reaches the period
				if (x_cnt_inc >= next_x_period) begin
					x_cnt <= '0;
					ball_x <= next_right ? ball_x + 1'b1 : ball_x - 1'b1;
				end else begin
					x_cnt <= x_cnt_inc;
				end
				if (y_cnt_inc >= next_y_period) begin
					y_cnt <= '0;
					ball_y <= next_down ? ball_y + 1'b1 : ball_y - 1'b1;
				end else begin
					y_cnt <= y_cnt_inc;
				end
			end
		end
	end

endmodule

// File: source/court_painter.sv
// Streams the court boundary row and the centre column once per start pulse
module court_painter (
	input logic clk,
	input logic resetn,
	input logic court_start,
	output logic court_pixel_valid,
	output screen_pkg::x_t court_x,
	output screen_pkg::y_t court_y,
	output logic court_done
);
	import screen_pkg::*;

	logic active;
	// Second stage, walking the centre column
	logic vertical;
	x_t cx;
	y_t cy;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			active <= 1'b0;
			vertical <= 1'b0;
			cx <= '0;
			cy <= '0;
		end else if (court_start) begin
			active <= 1'b1;
			vertical <= 1'b0;
			cx <= '0;
		end else if (active && !vertical) begin
			// End of top row, centre column starts under it
			if (cx == x_t'(SCREEN_W - 1)) begin
				vertical <= 1'b1;
				cy <= COURT_TOP + 1'b1;
			end else begin
				cx <= cx + 1'b1;
			end
		end else if (active) begin
			if (cy == y_t'(SCREEN_H - 1)) begin
				active <= 1'b0;
			end else begin
				cy <= cy + 1'b1;
			end
		end
	end

	assign court_pixel_valid = active;
	assign court_x = vertical ? CENTRE_X : cx;
	assign court_y = vertical ? cy : COURT_TOP;
	// Last pixel is the bottom of the centre column
	assign court_done = active && vertical && (cy == y_t'(SCREEN_H - 1));

endmodule

// File: source/draw_sequencer.sv
// Frame tick and phase FSM that picks a pixel source, applies colour and registers the output
module draw_sequencer #(
	parameter int frame_cycles = 833333
) (
	input logic clk,
	input logic resetn,
	input logic court_pixel_valid,
	input screen_pkg::x_t court_x,
	input screen_pkg::y_t court_y,
	input logic court_done,
	input logic paddle_pixel_valid,
	input screen_pkg::x_t paddle_x,
	input screen_pkg::y_t paddle_y,
	input logic paddles_done,
	input screen_pkg::x_t ball_x,
	input screen_pkg::y_t ball_y,
	input game_pkg::score_t score_p1,
	input game_pkg::score_t score_p2,
	output logic court_start,
	output logic paddle_draw,
	output logic frame_update,
	output screen_pkg::x_t pixel_x,
	output screen_pkg::y_t pixel_y,
	output screen_pkg::colour_t colour,
	output logic plot,
	output logic game_over
);
	import screen_pkg::*;
	import game_pkg::*;

	phase_t phase;
	phase_t phase_next;

	// Frame tick counter
	logic [$clog2(frame_cycles)-1:0] tick_cnt;
	logic tick;

	// Selected source pixel, before the output register
	logic src_valid;
	x_t src_x;
	y_t src_y;
	colour_t src_colour;

	assign tick = (tick_cnt == $bits(tick_cnt)'(frame_cycles - 1));

	// Free running, ticks outside WAIT are simply missed
	always_ff @(posedge clk) begin
		if (!resetn || tick) begin
			tick_cnt <= '0;
		end else begin
			tick_cnt <= tick_cnt + 1'b1;
		end
	end

	// Either player at the win score
	assign game_over = (score_p1 >= WIN_SCORE) || (score_p2 >= WIN_SCORE);

	always_comb begin
		phase_next = phase;
		case (phase)
			INIT:          phase_next = COURT;
			COURT:         phase_next = court_done ? WAIT : COURT;
			WAIT:          phase_next = tick ? ERASE_PADDLES : WAIT;
			ERASE_PADDLES: phase_next = paddles_done ? ERASE_BALL : ERASE_PADDLES;
			ERASE_BALL:    phase_next = UPDATE;
			UPDATE:        phase_next = DRAW_PADDLES;
			DRAW_PADDLES:  phase_next = paddles_done ? DRAW_BALL : DRAW_PADDLES;
			// Frame ends here, freeze once someone has won
			DRAW_BALL:     phase_next = game_over ? OVER : WAIT;
			OVER:          phase_next = OVER;
			default:       phase_next = INIT;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			phase <= INIT;
		end else begin
			phase <= phase_next;
		end
	end

	// Unit controls
	assign court_start = (phase == INIT);
	assign paddle_draw = (phase == ERASE_PADDLES) || (phase == DRAW_PADDLES);
	assign frame_update = (phase == UPDATE);

	// Source select and colour rules
	always_comb begin
		src_valid = 1'b0;
		src_x = ball_x;
		src_y = ball_y;
		src_colour = COLOUR_WHITE;
		case (phase)
			COURT: begin
				src_valid = court_pixel_valid;
				src_x = court_x;
				src_y = court_y;
			end
			ERASE_PADDLES: begin
				src_valid = paddle_pixel_valid;
				src_x = paddle_x;
				src_y = paddle_y;
				src_colour = COLOUR_BLACK;
			end
			DRAW_PADDLES: begin
				src_valid = paddle_pixel_valid;
				src_x = paddle_x;
				src_y = paddle_y;
			end
			ERASE_BALL: begin
				src_valid = 1'b1;
				// Ball over the centre line puts the line back
				src_colour = (ball_x == CENTRE_X) ? COLOUR_WHITE : COLOUR_BLACK;
			end
			DRAW_BALL: begin
				src_valid = 1'b1;
			end
			default: begin
				src_valid = 1'b0;
			end
		endcase
	end

	// Strobe, one cycle behind the source
	always_ff @(posedge clk) begin
		if (!resetn) begin
			plot <= 1'b0;
		end else begin
			plot <= src_valid;
		end
	end

	// Pixel payload
	always_ff @(posedge clk) begin
		pixel_x <= src_x;
		pixel_y <= src_y;
		colour <= src_colour;
	end

endmodule

// File: source/game_pkg.sv
// Game rules shared by the sequencer, ball unit and testbench: phases, scores, angle table
package game_pkg;

	// Sequencer phases, court once, then the per-frame loop
	typedef enum logic [3:0] {
		INIT          = 4'd0,
		COURT         = 4'd1,
		WAIT          = 4'd2,
		ERASE_PADDLES = 4'd3,
		ERASE_BALL    = 4'd4,
		UPDATE        = 4'd5,
		DRAW_PADDLES  = 4'd6,
		DRAW_BALL     = 4'd7,
		OVER          = 4'd8
	} phase_t;

	// Score per player
	typedef logic [3:0] score_t;

	// First player to this wins and the game freezes
	localparam score_t WIN_SCORE = 4'd10;

	// Angle zones along a paddle
	localparam int ZONE_ROWS = 2;
	localparam int ZONE_COUNT = 10;

	// Frames per one-pixel step
	typedef logic [1:0] period_t;

	// Steepness index
	// 0 is 75 deg, 1 is 60, 2 is 45, 3 is 30, 4 is 15
	localparam int STEEP_45 = 2;

	// Frames per x step, steep angles crawl sideways
	localparam period_t zone_x_period [0:4] = '{
		2'd3,
		2'd2,
		2'd1,
		2'd1,
		2'd1
	};

	// Frames per y step, shallow angles crawl vertically
	localparam period_t zone_y_period [0:4] = '{
		2'd1,
		2'd1,
		2'd1,
		2'd2,
		2'd3
	};

endpackage

// File: source/paddle_unit.sv
// Paddle positions with button moves, plus a raster of both paddles for erase and draw
module paddle_unit (
	input logic clk,
	input logic resetn,
	input logic p1_up,
	input logic p1_down,
	input logic p2_up,
	input logic p2_down,
	input logic frame_update,
	input logic paddle_draw,
	output screen_pkg::y_t paddle1_y,
	output screen_pkg::y_t paddle2_y,
	output logic paddle_pixel_valid,
	output screen_pkg::x_t paddle_x,
	output screen_pkg::y_t paddle_y,
	output logic paddles_done
);
	import screen_pkg::*;

	// Raster state
	logic streaming;
	logic finished;
	// Low for paddle 1, high for paddle 2
	logic sel;
	logic [4:0] row;

	// One row per frame, up lowers y, conflicting buttons cancel
	function automatic y_t step_paddle(input y_t top, input logic up, input logic down);
		y_t next_top;
		next_top = top;
		if (up && !down && (top > PADDLE_TOP_MIN)) begin
			next_top = top - 1'b1;
		end else if (down && !up && (top < PADDLE_TOP_MAX)) begin
			next_top = top + 1'b1;
		end
		return next_top;
	endfunction

	// Positions only move in UPDATE
	always_ff @(posedge clk) begin
		if (!resetn) begin
			paddle1_y <= PADDLE_START_Y;
			paddle2_y <= PADDLE_START_Y;
		end else if (frame_update) begin
			paddle1_y <= step_paddle(paddle1_y, p1_up, p1_down);
			paddle2_y <= step_paddle(paddle2_y, p2_up, p2_down);
		end
	end

	// Dropping paddle_draw rearms the raster
	always_ff @(posedge clk) begin
		if (!resetn || !paddle_draw) begin
			streaming <= 1'b0;
			finished <= 1'b0;
			sel <= 1'b0;
			row <= '0;
		end else if (!streaming && !finished) begin
			streaming <= 1'b1;
		end else if (streaming) begin
			if (row == 5'(PADDLE_LEN - 1)) begin
				row <= '0;
				if (sel) begin
					streaming <= 1'b0;
					finished <= 1'b1;
				end else begin
					sel <= 1'b1;
				end
			end else begin
				row <= row + 1'b1;
			end
		end
	end

	assign paddle_pixel_valid = streaming;
	assign paddle_x = sel ? P2_X : P1_X;
	assign paddle_y = (sel ? paddle2_y : paddle1_y) + y_t'(row);
	// Bottom row of paddle 2
	assign paddles_done = streaming && sel && (row == 5'(PADDLE_LEN - 1));

endmodule

// File: source/pong_top.sv
// Pong game top level, emits frame buffer pixel writes from the sequencer and game units
module pong_top #(
	parameter int frame_cycles = 833333
) (
	input logic clk,
	input logic resetn,
	input logic p1_up,
	input logic p1_down,
	input logic p2_up,
	input logic p2_down,
	output screen_pkg::x_t pixel_x,
	output screen_pkg::y_t pixel_y,
	output screen_pkg::colour_t colour,
	output logic plot,
	output game_pkg::score_t score_p1,
	output game_pkg::score_t score_p2,
	output logic game_over
);
	import screen_pkg::*;

	// Court painter
	logic court_start;
	logic court_pixel_valid;
	x_t court_x;
	y_t court_y;
	logic court_done;

	// Paddle unit
	logic paddle_draw;
	logic frame_update;
	y_t paddle1_y;
	y_t paddle2_y;
	logic paddle_pixel_valid;
	x_t paddle_x;
	y_t paddle_y;
	logic paddles_done;

	// Ball unit
	x_t ball_x;
	y_t ball_y;

	draw_sequencer #(
		.frame_cycles(frame_cycles)
	) u_seq (
		.clk(clk),
		.resetn(resetn),
		.court_pixel_valid(court_pixel_valid),
		.court_x(court_x),
		.court_y(court_y),
		.court_done(court_done),
		.paddle_pixel_valid(paddle_pixel_valid),
		.paddle_x(paddle_x),
		.paddle_y(paddle_y),
		.paddles_done(paddles_done),
		.ball_x(ball_x),
		.ball_y(ball_y),
		.score_p1(score_p1),
		.score_p2(score_p2),
		.court_start(court_start),
		.paddle_draw(paddle_draw),
		.frame_update(frame_update),
		.pixel_x(pixel_x),
		.pixel_y(pixel_y),
		.colour(colour),
		.plot(plot),
		.game_over(game_over)
	);

	court_painter u_court (
		.clk(clk),
		.resetn(resetn),
		.court_start(court_start),
		.court_pixel_valid(court_pixel_valid),
		.court_x(court_x),
		.court_y(court_y),
		.court_done(court_done)
	);

	paddle_unit u_paddles (
		.clk(clk),
		.resetn(resetn),
		.p1_up(p1_up),
		.p1_down(p1_down),
		.p2_up(p2_up),
		.p2_down(p2_down),
		.frame_update(frame_update),
		.paddle_draw(paddle_draw),
		.paddle1_y(paddle1_y),
		.paddle2_y(paddle2_y),
		.paddle_pixel_valid(paddle_pixel_valid),
		.paddle_x(paddle_x),
		.paddle_y(paddle_y),
		.paddles_done(paddles_done)
	);

	ball_unit u_ball (
		.clk(clk),
		.resetn(resetn),
		.frame_update(frame_update),
		.paddle1_y(paddle1_y),
		.paddle2_y(paddle2_y),
		.ball_x(ball_x),
		.ball_y(ball_y),
		.score_p1(score_p1),
		.score_p2(score_p2)
	);

endmodule

// File: source/screen_pkg.sv
// Screen geometry, pixel types and court placement shared by the RTL and the testbench
package screen_pkg;

	// Pixel coordinates for a 160x120 frame buffer
	typedef logic [7:0] x_t;
	typedef logic [6:0] y_t;

	// One bit per RGB channel
	typedef logic [2:0] colour_t;

	localparam int SCREEN_W = 160;
	localparam int SCREEN_H = 120;

	// Court lines
	localparam y_t COURT_TOP = 7'd30;
	localparam x_t CENTRE_X = 8'd80;

	localparam colour_t COLOUR_WHITE = 3'b111;
	localparam colour_t COLOUR_BLACK = 3'b000;

	// Paddles, both vertical and one pixel wide
	localparam int PADDLE_LEN = 20;
	localparam x_t P1_X = 8'd5;
	localparam x_t P2_X = 8'd155;
	localparam y_t PADDLE_START_Y = 7'd75;

	// Top row clamp keeps the paddle under the boundary and on screen
	localparam y_t PADDLE_TOP_MIN = 7'd31;
	localparam y_t PADDLE_TOP_MAX = 7'd98;

	// Ball serve point and bounce rows
	localparam x_t BALL_START_X = 8'd80;
	localparam y_t BALL_START_Y = 7'd75;
	localparam y_t BALL_Y_MIN = 7'd32;
	localparam y_t BALL_Y_MAX = 7'd119;

endpackage

// File: verif/pong_chk.sv
// Concurrent checks on the sequencer pixel output, bound into draw_sequencer by the testbench
module pong_chk (
	input logic clk,
	input logic resetn,
	input game_pkg::phase_t phase,
	input logic plot,
	input screen_pkg::x_t pixel_x,
	input screen_pkg::y_t pixel_y,
	input screen_pkg::colour_t colour
);
	import screen_pkg::*;
	import game_pkg::*;

	// Failure count, polled from the testbench
	int assert_fails = 0;

	// Last ball pixel lands on the first OVER cycle, nothing after that
	over_quiet: assert property (@(posedge clk) disable iff (!resetn)
		(phase == OVER) |=> !plot)
	else begin
		assert_fails++;
		$error("plot high while the game is frozen");
	end

	// Frame buffer is 160x120
	on_screen: assert property (@(posedge clk) disable iff (!resetn)
		plot |-> (pixel_x < SCREEN_W) && (pixel_y < SCREEN_H))
	else begin
		assert_fails++;
		$error("pixel written off screen at (%0d,%0d)", pixel_x, pixel_y);
	end

	// Only two colours ever reach the buffer
	two_colours: assert property (@(posedge clk) disable iff (!resetn)
		plot |-> (colour == COLOUR_WHITE) || (colour == COLOUR_BLACK))
	else begin
		assert_fails++;
		$error("unexpected colour %0d", colour);
	end

endmodule

// File: verif/pong_tb.sv
// Testbench for pong_top: random buttons per frame, reference model, pixel and score checks
module pong_tb;
	import screen_pkg::*;
	import game_pkg::*;

	localparam int FRAME_CYCLES = 128;
	localparam int CLK_PERIOD = 8;
	localparam int WATCHDOG_FRAMES = 1200;
	// Frames checked, leaves room for reset, court and freeze under the watchdog
	localparam int FRAME_LIMIT = 1150;
	localparam int FREEZE_CYCLES = 3 * FRAME_CYCLES;

	logic clk;
	logic resetn;
	logic p1_up;
	logic p1_down;
	logic p2_up;
	logic p2_down;
	x_t pixel_x;
	y_t pixel_y;
	colour_t colour;
	logic plot;
	score_t score_p1;
	score_t score_p2;
	logic game_over;

	logic [31:0] rng_state;
	int frame;

	// Reference model
	y_t m_p1_top;
	y_t m_p2_top;
	x_t m_ball_x;
	y_t m_ball_y;
	logic m_right;
	logic m_down;
	int m_x_period;
	int m_y_period;
	int m_x_cnt;
	int m_y_cnt;
	score_t m_score_p1;
	score_t m_score_p2;

	pong_top #(
		.frame_cycles(FRAME_CYCLES)
	) u_dut (
		.clk(clk),
		.resetn(resetn),
		.p1_up(p1_up),
		.p1_down(p1_down),
		.p2_up(p2_up),
		.p2_down(p2_down),
		.pixel_x(pixel_x),
		.pixel_y(pixel_y),
		.colour(colour),
		.plot(plot),
		.score_p1(score_p1),
		.score_p2(score_p2),
		.game_over(game_over)
	);

	bind draw_sequencer pong_chk u_chk (
		.clk(clk),
		.resetn(resetn),
		.phase(phase),
		.plot(plot),
		.pixel_x(pixel_x),
		.pixel_y(pixel_y),
		.colour(colour)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("Simulation finished: FAIL");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_pixel(input x_t got_x, input y_t got_y, input colour_t got_c,
		input x_t exp_x, input y_t exp_y, input colour_t exp_c, input string what);
		if (got_x !== exp_x || got_y !== exp_y || got_c !== exp_c) begin
			abort_run($sformatf(
				"Fail at %0t: %s got (%0d,%0d) colour %0d, want (%0d,%0d) colour %0d",
				$time, what, got_x, got_y, got_c, exp_x, exp_y, exp_c));
		end
	endtask

	task automatic check_score(input score_t got, input score_t exp, input string what);
		if (got !== exp) begin
			abort_run($sformatf("Fail at %0t: %s is %0d, want %0d", $time, what, got, exp));
		end
	endtask

	task automatic check_flag(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			abort_run($sformatf("Fail at %0t: %s is %b, want %b", $time, what, got, exp));
		end
	endtask

	// Assertion failures in the bound checker end the run
	always @(negedge clk) begin
		if (u_dut.u_seq.u_chk.assert_fails != 0) begin
			abort_run("A sequencer assertion failed, see the error above");
		end
	end

	initial begin
		#(WATCHDOG_FRAMES * FRAME_CYCLES * CLK_PERIOD);
		abort_run("Watchdog expired before the frame checks completed");
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// Frames per x step, steepness 0 is 75 deg and 4 is 15 deg
	function automatic int x_frames(input int steep);
		if (steep == 0) begin
			return 3;
		end
		return (steep == 1) ? 2 : 1;
	endfunction

	function automatic int y_frames(input int steep);
		if (steep == 4) begin
			return 3;
		end
		return (steep == 3) ? 2 : 1;
	endfunction

	function automatic y_t paddle_move(input y_t top, input logic up, input logic down);
		int t;
		t = top;
		if (up && !down) begin
			t = t - 1;
		end else if (down && !up) begin
			t = t + 1;
		end
		// Clamp to the court
		t = (t < PADDLE_TOP_MIN) ? PADDLE_TOP_MIN : t;
		t = (t > PADDLE_TOP_MAX) ? PADDLE_TOP_MAX : t;
		return y_t'(t);
	endfunction

	function automatic logic model_over();
		return (m_score_p1 >= WIN_SCORE) || (m_score_p2 >= WIN_SCORE);
	endfunction

	// Serve from the centre at 45 deg heading down
	task automatic model_serve(input logic right);
		m_ball_x = BALL_START_X;
		m_ball_y = BALL_START_Y;
		m_right = right;
		m_down = 1'b1;
		m_x_period = 1;
		m_y_period = 1;
		m_x_cnt = 0;
		m_y_cnt = 0;
	endtask

	// One UPDATE, ball sees the paddles from before their move
	task automatic model_frame(input logic u1, input logic d1, input logic u2, input logic d2);
		int top;
		int zone;
		int steep;
		if (m_ball_x <= 1 || m_ball_x >= SCREEN_W - 1) begin
			if (m_ball_x <= 1) begin
				m_score_p2 = m_score_p2 + 1'b1;
			end else begin
				m_score_p1 = m_score_p1 + 1'b1;
			end
			model_serve(m_ball_x > 1);
		end else begin
			if (m_ball_y <= BALL_Y_MIN) begin
				m_down = 1'b1;
			end else if (m_ball_y >= BALL_Y_MAX) begin
				m_down = 1'b0;
			end
			if (m_ball_x == P1_X + 2 || m_ball_x == P2_X - 2) begin
				top = (m_ball_x == P1_X + 2) ? m_p1_top : m_p2_top;
				if (m_ball_y >= top && m_ball_y < top + PADDLE_LEN) begin
					// Zones 0 to 4 send the ball up, mirrored below
					zone = (m_ball_y - top) / 2;
					steep = (zone < 5) ? zone : 9 - zone;
					m_right = (m_ball_x == P1_X + 2);
					m_down = (zone >= 5);
					m_x_period = x_frames(steep);
					m_y_period = y_frames(steep);
				end
			end
			m_x_cnt++;
			if (m_x_cnt >= m_x_period) begin
				m_x_cnt = 0;
				m_ball_x = m_right ? m_ball_x + 1'b1 : m_ball_x - 1'b1;
			end
			m_y_cnt++;
			if (m_y_cnt >= m_y_period) begin
				m_y_cnt = 0;
				m_ball_y = m_down ? m_ball_y + 1'b1 : m_ball_y - 1'b1;
			end
		end
		m_p1_top = paddle_move(m_p1_top, u1, d1);
		m_p2_top = paddle_move(m_p2_top, u2, d2);
	endtask

	// Next plotted pixel, sampled on the falling edge
	task automatic next_pixel(output x_t x, output y_t y, output colour_t c);
		@(negedge clk);
		while (plot !== 1'b1) begin
			@(negedge clk);
		end
		x = pixel_x;
		y = pixel_y;
		c = colour;
	endtask

	task automatic expect_pixel(input x_t x, input y_t y, input colour_t c, input string what);
		x_t gx;
		y_t gy;
		colour_t gc;
		next_pixel(gx, gy, gc);
		check_pixel(gx, gy, gc, x, y, c, what);
	endtask

	// Paddle 1 top to bottom, then paddle 2
	task automatic expect_paddles(input colour_t c, input string what);
		x_t gx;
		y_t gy;
		colour_t gc;
		for (int p = 0; p < 2; p++) begin
			for (int r = 0; r < PADDLE_LEN; r++) begin
				next_pixel(gx, gy, gc);
				check_pixel(gx, gy, gc, (p == 0) ? P1_X : P2_X,
					((p == 0) ? m_p1_top : m_p2_top) + y_t'(r), c, what);
			end
		end
	endtask

	initial begin
		clk = 1'b0;
		resetn = 1'b0;
		p1_up = 1'b0;
		p1_down = 1'b0;
		p2_up = 1'b0;
		p2_down = 1'b0;
		rng_state = 32'h7e4d_155a;
		m_p1_top = PADDLE_START_Y;
		m_p2_top = PADDLE_START_Y;
		m_score_p1 = '0;
		m_score_p2 = '0;
		model_serve(1'b1);
		repeat (5) @(posedge clk);
		resetn <= 1'b1;
		@(negedge clk);
		check_flag(plot, 1'b0, "plot after reset");
		check_flag(game_over, 1'b0, "game_over after reset");
		check_score(score_p1, '0, "score_p1 after reset");
		check_score(score_p2, '0, "score_p2 after reset");
		// Court, top row left to right then centre column downward
		for (int i = 0; i < SCREEN_W; i++) begin
			expect_pixel(x_t'(i), COURT_TOP, COLOUR_WHITE, "court row");
		end
		for (int i = COURT_TOP + 1; i < SCREEN_H; i++) begin
			expect_pixel(CENTRE_X, y_t'(i), COLOUR_WHITE, "centre line");
		end
		frame = 0;
		while (!model_over() && frame < FRAME_LIMIT) begin
			// New buttons while the sequencer waits for its tick
			@(posedge clk);
			rng_state = lcg_next(rng_state);
			p1_up <= rng_state[31];
			p1_down <= rng_state[30];
			p2_up <= rng_state[29];
			p2_down <= rng_state[28];
			expect_paddles(COLOUR_BLACK, "paddle erase");
			expect_pixel(m_ball_x, m_ball_y,
				(m_ball_x == CENTRE_X) ? COLOUR_WHITE : COLOUR_BLACK, "ball erase");
			model_frame(rng_state[31], rng_state[30], rng_state[29], rng_state[28]);
			expect_paddles(COLOUR_WHITE, "paddle draw");
			expect_pixel(m_ball_x, m_ball_y, COLOUR_WHITE, "ball draw");
			check_score(score_p1, m_score_p1, "score_p1");
			check_score(score_p2, m_score_p2, "score_p2");
			check_flag(game_over, model_over(), "game_over");
			frame++;
		end
		if (model_over()) begin
			// Frozen game, nothing plotted and nothing scored
			repeat (FREEZE_CYCLES) begin
				@(negedge clk);
				check_flag(plot, 1'b0, "plot after game over");
				check_flag(game_over, 1'b1, "game_over held");
				check_score(score_p1, m_score_p1, "score_p1 held");
				check_score(score_p2, m_score_p2, "score_p2 held");
			end
		end
		if (u_dut.u_seq.u_chk.assert_fails != 0) begin
			abort_run("A sequencer assertion failed, see the error above");
		end else begin
			$display("Frames checked: %0d, scores %0d to %0d", frame, m_score_p1, m_score_p2);
			$display("Simulation finished: PASS");
			$finish;
		end
	end

endmodule
